// ==== hdl/zk_op_pkg.sv ====
/*
 * Opcode encoding and word types of the crypto execute unit.
 * Codes 17 to 31 are unassigned and are reported as errors.
 */
package zk_op_pkg;

    localparam int xlen_p = 32;
    localparam int op_width_p = 5;

    typedef logic [xlen_p-1:0] word_t;
    typedef logic [$clog2(xlen_p)-1:0] shamt_t;

    // numeric codes are shared with the stimulus file
    typedef enum logic [op_width_p-1:0] {
        op_ror         = 5'd0,
        op_rol         = 5'd1,
        op_andn        = 5'd2,
        op_orn         = 5'd3,
        op_xnor        = 5'd4,
        op_pack        = 5'd5,
        op_packh       = 5'd6,
        op_brev8       = 5'd7,
        op_rev8        = 5'd8,
        op_zip         = 5'd9,
        op_unzip       = 5'd10,
        op_sha256_sig0 = 5'd11,
        op_sha256_sig1 = 5'd12,
        op_sha256_sum0 = 5'd13,
        op_sha256_sum1 = 5'd14,
        op_sm3_p0      = 5'd15,
        op_sm3_p1      = 5'd16
    } zk_op_e;

endpackage

// ==== hdl/zk_const_pkg.sv ====
/*
 * Fixed rotate and shift amounts of the SHA-256 and SM3 functions.
 */
package zk_const_pkg;
    import zk_op_pkg::*;

    localparam shamt_t sig0_r1_c = 5'd7;
    localparam shamt_t sig0_r2_c = 5'd18;
    localparam shamt_t sig0_sh_c = 5'd3;

    localparam shamt_t sig1_r1_c = 5'd17;
    localparam shamt_t sig1_r2_c = 5'd19;
    localparam shamt_t sig1_sh_c = 5'd10;

    localparam shamt_t sum0_r1_c = 5'd2;
    localparam shamt_t sum0_r2_c = 5'd13;
    localparam shamt_t sum0_r3_c = 5'd22;

    localparam shamt_t sum1_r1_c = 5'd6;
    localparam shamt_t sum1_r2_c = 5'd11;
    localparam shamt_t sum1_r3_c = 5'd25;

    // sm3 rotates are to the left
    localparam shamt_t p0_l1_c = 5'd9;
    localparam shamt_t p0_l2_c = 5'd17;
    localparam shamt_t p1_l1_c = 5'd15;
    localparam shamt_t p1_l2_c = 5'd23;

    function automatic word_t ror_f(word_t x, shamt_t amt);
        return (x >> amt) | (x << (xlen_p - amt));
    endfunction

    function automatic word_t rol_f(word_t x, shamt_t amt);
        return (x << amt) | (x >> (xlen_p - amt));
    endfunction

endpackage

// ==== hdl/zk_op_if.sv ====
/*
 * Latched operation out to the datapaths, results and hits back.
 * A unit drives a zero result for any opcode it does not hit.
 */
`timescale 1ns/1ns

interface zk_op_if import zk_op_pkg::*; (
    input logic clk_i
);
    zk_op_e op;
    word_t  operand_a;
    word_t  operand_b;

    word_t  bm_result;
    logic   bm_hit;
    word_t  hash_result;
    logic   hash_hit;

    modport ctrl_mp (
        output op, operand_a, operand_b,
        input  bm_result, bm_hit, hash_result, hash_hit
    );

    // clock is only there for the checker in the datapath
    modport bitmanip_mp (
        input  clk_i, op, operand_a, operand_b,
        output bm_result, bm_hit
    );

    modport hash_mp (
        input  op, operand_a,
        output hash_result, hash_hit
    );
endinterface

// ==== hdl/zk_ctrl.sv ====
/*
 * Four-phase request/acknowledge control. One request at a time.
 * ack_o rises two edges after capture and falls on the edge that sees req_i low.
 * req_i must not be raised again before ack_o is low.
 */
`timescale 1ns/1ns

module zk_ctrl import zk_op_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     req_i,
    input  zk_op_e   op_i,
    input  word_t    operand_a_i,
    input  word_t    operand_b_i,
    output logic     ack_o,
    output word_t    result_o,
    output logic     err_o,
    zk_op_if.ctrl_mp bus
);
    typedef enum logic [1:0] {
        idle_s,
        compute_s,
        ack_s
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   capture;
    zk_op_e op_q;
    word_t  operand_a_q;
    word_t  operand_b_q;
    word_t  result_q;
    logic   err_q;
    logic   ack_q;

    assign capture = (state_q == idle_s) && req_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            idle_s: begin
                if (req_i) begin
                    state_d = compute_s;
                end
            end
            compute_s: state_d = ack_s;
            ack_s: begin
                if (!req_i) begin
                    state_d = idle_s;
                end
            end
            default: state_d = idle_s;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= idle_s;
            op_q     <= op_ror;
            result_q <= '0;
            err_q    <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            // ack follows the result register by one edge
            ack_q   <= (state_q == ack_s) && req_i;
            if (capture) begin
                op_q <= op_i;
            end
            if (state_q == compute_s) begin
                result_q <= bus.bm_result | bus.hash_result;
                err_q    <= !(bus.bm_hit || bus.hash_hit);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            operand_a_q <= operand_a_i;
            operand_b_q <= operand_b_i;
        end
    end

    assign bus.op        = op_q;
    assign bus.operand_a = operand_a_q;
    assign bus.operand_b = operand_b_q;

    assign ack_o    = ack_q;
    assign result_o = result_q;
    assign err_o    = err_q;

    // request held from capture until ack
    assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(ack_o) |-> $past(req_i, 1) && $past(req_i, 2) && $past(req_i, 3));

    // opcode ranges of the two datapaths are disjoint
    assert property (@(posedge clk_i) disable iff (reset_i)
        !(bus.bm_hit && bus.hash_hit));

endmodule

// ==== hdl/zk_bitmanip_unit.sv ====
/*
 * Combinational bit-manipulation datapath for opcodes 0 to 10.
 * Rotates use only the low 5 bits of operand b.
 */
`timescale 1ns/1ns

module zk_bitmanip_unit import zk_op_pkg::*; (
    zk_op_if.bitmanip_mp bus
);
    word_t  a;
    word_t  b;
    shamt_t shamt;

    assign a     = bus.operand_a;
    assign b     = bus.operand_b;
    assign shamt = b[$bits(shamt_t)-1:0];

    logic ror_sel, rol_sel, andn_sel, orn_sel, xnor_sel;
    logic pack_sel, packh_sel, brev8_sel, rev8_sel, zip_sel, unzip_sel;

    assign ror_sel   = (bus.op == op_ror);
    assign rol_sel   = (bus.op == op_rol);
    assign andn_sel  = (bus.op == op_andn);
    assign orn_sel   = (bus.op == op_orn);
    assign xnor_sel  = (bus.op == op_xnor);
    assign pack_sel  = (bus.op == op_pack);
    assign packh_sel = (bus.op == op_packh);
    assign brev8_sel = (bus.op == op_brev8);
    assign rev8_sel  = (bus.op == op_rev8);
    assign zip_sel   = (bus.op == op_zip);
    assign unzip_sel = (bus.op == op_unzip);

    // rotates on a doubled word
    logic [2*xlen_p-1:0] dbl_r;
    logic [2*xlen_p-1:0] dbl_l;
    word_t w_ror, w_rol, w_andn, w_orn, w_xnor, w_pack, w_packh;
    word_t w_brev8, w_rev8, w_zip, w_unzip;

    assign dbl_r = {a, a} >> shamt;
    assign dbl_l = {a, a} << shamt;
    assign w_ror = dbl_r[xlen_p-1:0];
    assign w_rol = dbl_l[2*xlen_p-1:xlen_p];

    assign w_andn  = a & ~b;
    assign w_orn   = a | ~b;
    assign w_xnor  = a ^ ~b;
    assign w_pack  = {b[15:0], a[15:0]};
    assign w_packh = {16'd0, b[7:0], a[7:0]};
    assign w_rev8  = {a[7:0], a[15:8], a[23:16], a[31:24]};

    always_comb begin
        for (int i = 0; i < xlen_p / 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                w_brev8[8*i + j] = a[8*i + 7 - j];
            end
        end
        // even bits from the low half, odd bits from the high half
        for (int i = 0; i < xlen_p / 2; i++) begin
            w_zip[2*i]              = a[i];
            w_zip[2*i + 1]          = a[i + xlen_p/2];
            w_unzip[i]              = a[2*i];
            w_unzip[i + xlen_p/2]   = a[2*i + 1];
        end
    end

    assign bus.bm_hit = |{ror_sel, rol_sel, andn_sel, orn_sel, xnor_sel,
                          pack_sel, packh_sel, brev8_sel, rev8_sel, zip_sel, unzip_sel};

    assign bus.bm_result = {xlen_p{ror_sel}}   & w_ror   |
                           {xlen_p{rol_sel}}   & w_rol   |
                           {xlen_p{andn_sel}}  & w_andn  |
                           {xlen_p{orn_sel}}   & w_orn   |
                           {xlen_p{xnor_sel}}  & w_xnor  |
                           {xlen_p{pack_sel}}  & w_pack  |
                           {xlen_p{packh_sel}} & w_packh |
                           {xlen_p{brev8_sel}} & w_brev8 |
                           {xlen_p{rev8_sel}}  & w_rev8  |
                           {xlen_p{zip_sel}}   & w_zip   |
                           {xlen_p{unzip_sel}} & w_unzip;

    // a miss must not leak into the OR at the control side
    assert property (@(posedge bus.clk_i)
        !bus.bm_hit |-> (bus.bm_result == '0));

endmodule

// ==== hdl/zk_hash_unit.sv ====
/*
 * Combinational SHA-256 sigma/sum and SM3 P0/P1 datapath, opcodes 11 to 16.
 * Only operand a is used.
 */
`timescale 1ns/1ns

module zk_hash_unit import zk_op_pkg::*, zk_const_pkg::*; (
    zk_op_if.hash_mp bus
);
    word_t a;

    assign a = bus.operand_a;

    logic sig0_sel, sig1_sel, sum0_sel, sum1_sel, p0_sel, p1_sel;

    assign sig0_sel = (bus.op == op_sha256_sig0);
    assign sig1_sel = (bus.op == op_sha256_sig1);
    assign sum0_sel = (bus.op == op_sha256_sum0);
    assign sum1_sel = (bus.op == op_sha256_sum1);
    assign p0_sel   = (bus.op == op_sm3_p0);
    assign p1_sel   = (bus.op == op_sm3_p1);

    word_t sig0, sig1, sum0, sum1, p0, p1;

    // sigma ends in a plain shift, sum is rotates only
    assign sig0 = ror_f(a, sig0_r1_c) ^ ror_f(a, sig0_r2_c) ^ (a >> sig0_sh_c);
    assign sig1 = ror_f(a, sig1_r1_c) ^ ror_f(a, sig1_r2_c) ^ (a >> sig1_sh_c);
    assign sum0 = ror_f(a, sum0_r1_c) ^ ror_f(a, sum0_r2_c) ^ ror_f(a, sum0_r3_c);
    assign sum1 = ror_f(a, sum1_r1_c) ^ ror_f(a, sum1_r2_c) ^ ror_f(a, sum1_r3_c);

    assign p0 = a ^ rol_f(a, p0_l1_c) ^ rol_f(a, p0_l2_c);
    assign p1 = a ^ rol_f(a, p1_l1_c) ^ rol_f(a, p1_l2_c);

    assign bus.hash_hit = |{sig0_sel, sig1_sel, sum0_sel, sum1_sel, p0_sel, p1_sel};

    assign bus.hash_result = {xlen_p{sig0_sel}} & sig0 |
                             {xlen_p{sig1_sel}} & sig1 |
                             {xlen_p{sum0_sel}} & sum0 |
                             {xlen_p{sum1_sel}} & sum1 |
                             {xlen_p{p0_sel}}   & p0   |
                             {xlen_p{p1_sel}}   & p1;

endmodule

// ==== hdl/zk_top.sv ====
/*
 * Scalar-crypto execute unit with a four-phase req/ack front end.
 * Fixed latency of 2 cycles from capture to ack_o.
 * With enable_hash_p = 0 the hash opcodes report err_o.
 */
`timescale 1ns/1ns

module zk_top import zk_op_pkg::*; #(
    parameter bit enable_hash_p = 1'b1
) (
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   req_i,
    input  zk_op_e op_i,
    input  word_t  operand_a_i,
    input  word_t  operand_b_i,
    output logic   ack_o,
    output word_t  result_o,
    output logic   err_o
);
    zk_op_if bus (
        .clk_i (clk_i)
    );

    zk_ctrl u_ctrl (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_i       (req_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .ack_o       (ack_o),
        .result_o    (result_o),
        .err_o       (err_o),
        .bus         (bus.ctrl_mp)
    );

    zk_bitmanip_unit u_bitmanip (
        .bus (bus.bitmanip_mp)
    );

    if (enable_hash_p) begin : gen_hash
        zk_hash_unit u_hash (
            .bus (bus.hash_mp)
        );
    end else begin : gen_no_hash
        // no hit, so hash opcodes fall through to the error flag
        assign bus.hash_result = '0;
        assign bus.hash_hit    = 1'b0;
    end

endmodule

// ==== tests/zk_top_tb.sv ====
/*
 * Testbench for zk_top. Vectors come from tests/zk_stimulus.txt, so the run
 * has to start in the project root. Five hex words per vector, and an
 * opcode word of ffffffff ends the list.
 */
`timescale 1ns/1ns

module zk_top_tb import zk_op_pkg::*; ();
    localparam int max_vec_c = 64;
    localparam int timeout_c = 20;

    logic   clk;
    logic   reset;
    logic   req;
    zk_op_e op;
    word_t  operand_a;
    word_t  operand_b;
    logic   ack;
    word_t  result;
    logic   err;

    logic [31:0] stim_mem [0:5*max_vec_c-1];
    logic [31:0] lcg_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    zk_top u_dut (
        .clk_i       (clk),
        .reset_i     (reset),
        .req_i       (req),
        .op_i        (op),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .ack_o       (ack),
        .result_o    (result),
        .err_o       (err)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_value(input string name, input word_t exp_v, input word_t got_v);
        $display("[ERROR] %0t %s: expected %h got %h", $time, name, exp_v, got_v);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("timed out after %0d cycles waiting for %s", timeout_c, what);
        errors++;
        timed_out = 1'b1;
    endtask

    // one line per finished test
    task automatic log_test(input string label, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %s failed", label);
        end else begin
            $display("test %s ok", label);
        end
    endtask

    // one full four-phase transaction for vector idx
    task automatic run_vector(input int idx);
        logic [4:0] code;
        word_t      exp_result;
        logic       exp_err;
        int         idle;
        int         hold;
        int         cycles;
        int         k;
        int         errors_before;
        string      label;

        code          = stim_mem[5*idx][4:0];
        exp_result    = stim_mem[5*idx+3];
        exp_err       = stim_mem[5*idx+4][0];
        errors_before = errors;
        label         = $sformatf("%0d op %0d", idx, code);
        lcg_state     = lcg_next(lcg_state);
        idle          = int'(lcg_state[18:16]);
        hold          = int'(lcg_state[26:24]) % 6;

        repeat (idle) @(posedge clk);
        @(posedge clk);
        op        <= zk_op_e'(code);
        operand_a <= stim_mem[5*idx+1];
        operand_b <= stim_mem[5*idx+2];
        req       <= 1'b1;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack && cycles < timeout_c);
        if (!ack) begin
            report_timeout("ack_o to rise");
            log_test(label, errors_before);
            return;
        end
        // req is sampled one edge after it is driven
        if (cycles - 2 != 2) begin
            $display("[ERROR] %0t ack_o latency: expected 2 got %0d", $time, cycles - 2);
            errors++;
        end
        if (result !== exp_result) begin
            report_value("result_o", exp_result, result);
        end
        if (err !== exp_err) begin
            report_value("err_o", {31'd0, exp_err}, {31'd0, err});
        end

        // back-pressure, outputs must hold
        for (k = 0; k < hold; k++) begin
            @(negedge clk);
            if (ack !== 1'b1) begin
                report_value("ack_o", 32'd1, {31'd0, ack});
            end
            if (result !== exp_result) begin
                report_value("result_o", exp_result, result);
            end
            if (err !== exp_err) begin
                report_value("err_o", {31'd0, exp_err}, {31'd0, err});
            end
        end

        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack && cycles < timeout_c);
        if (ack) begin
            report_timeout("ack_o to fall");
            log_test(label, errors_before);
            return;
        end
        if (cycles - 1 != 1) begin
            $display("[ERROR] %0t ack_o fall delay: expected 1 got %0d", $time, cycles - 1);
            errors++;
        end

        log_test(label, errors_before);
    endtask

    initial begin
        int n;
        int i;
        int errors_before;

        reset        = 1'b1;
        req          = 1'b0;
        op           = op_ror;
        operand_a    = '0;
        operand_b    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        lcg_state    = 32'he6ef;

        $readmemh("tests/zk_stimulus.txt", stim_mem);
        n = 0;
        while (n < max_vec_c && stim_mem[5*n] !== 32'hffff_ffff) begin
            n++;
        end

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // outputs idle after reset
        @(negedge clk);
        errors_before = errors;
        if (ack !== 1'b0) begin
            report_value("ack_o", 32'd0, {31'd0, ack});
        end
        if (err !== 1'b0) begin
            report_value("err_o", 32'd0, {31'd0, err});
        end
        if (result !== '0) begin
            report_value("result_o", 32'd0, result);
        end
        log_test("reset", errors_before);

        if (n == max_vec_c) begin
            $display("stimulus file could not be read or has no end marker");
            errors++;
            n = 0;
        end
        for (i = 0; i < n && !timed_out; i++) begin
            run_vector(i);
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tests/zk_stimulus.txt ====
// opcode operand_a operand_b expected_result expected_err, all hex
// an opcode of ffffffff ends the list
00 12345678 00000004 81234567 0
00 12345678 00000000 12345678 0
00 12345678 0000001f 2468acf0 0
00 12345678 00000024 81234567 0
01 12345678 00000008 34567812 0
01 80000001 0000001f c0000000 0
02 ff00ff00 0f0f0f0f f000f000 0
03 00ff00ff 0f0f0f0f f0fff0ff 0
04 aaaaaaaa 00000000 55555555 0
05 12345678 9abcdef0 def05678 0
06 12345678 9abcdef0 0000f078 0
07 12345678 00000000 482c6a1e 0
08 12345678 00000000 78563412 0
09 0000ffff 00000000 55555555 0
09 12345678 00000000 131c1f60 0
0a 131c1f60 00000000 12345678 0
0a 55555555 00000000 0000ffff 0
0b 00000000 00000000 00000000 0
0b ffffffff 00000000 1fffffff 0
// operand b must be ignored
0b 00000001 ffffffff 02004000 0
0c ffffffff 00000000 003fffff 0
0c 00000001 00000000 0000a000 0
0d ffffffff 00000000 ffffffff 0
0d 00000001 00000000 40080400 0
0e 00000000 00000000 00000000 0
0e 00000001 00000000 04200080 0
0f 00000001 00000000 00020201 0
0f ffffffff 00000000 ffffffff 0
10 00000001 00000000 00808001 0
10 ffffffff 00000000 ffffffff 0
// illegal opcodes
11 12345678 9abcdef0 00000000 1
1f 12345678 9abcdef0 00000000 1
ffffffff 00000000 00000000 00000000 0

// ==== zk_top.f ====
hdl/zk_op_pkg.sv
hdl/zk_const_pkg.sv
hdl/zk_op_if.sv
hdl/zk_ctrl.sv
hdl/zk_bitmanip_unit.sv
hdl/zk_hash_unit.sv
hdl/zk_top.sv
tests/zk_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the zk_top testbench with Verilator from the project root.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f zk_top.f \
    --top-module zk_top_tb \
    -o zk_top_sim

./obj_dir/zk_top_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
